/* include/f2h_uart_consts.svh */
// -----------------------------------------------
// UART register map, message lengths, bus widths
// and debounce timing
// -----------------------------------------------
`ifndef F2H_UART_CONSTS_SVH
`define F2H_UART_CONSTS_SVH

// UART controller behind the FPGA-to-HPS bridge
`define F2H_UART_BASE       32'hFFC02000
`define F2H_UART_THR_OFS    32'h00000000
`define F2H_UART_LSR_OFS    32'h00000014
`define F2H_UART_VER_ADDR   32'hFFC020F8
`define F2H_LSR_THRE_BIT    5

// Bus widths
`define F2H_ADDR_W          32
`define F2H_DATA_W          32

// Message lengths in characters
`define F2H_HELLO_LEN       26
`define F2H_PREFIX_LEN      12

// Push buttons
`define F2H_DEBOUNCE_CYCLES 50000
`define F2H_KEY_COUNT       2

`endif

/* logic/axi_pkg.sv */
// -----------------------------------------------
// Channel payloads and master command for the
// single-beat bridge transactions
// -----------------------------------------------
`include "f2h_uart_consts.svh"

package axi_pkg;

	typedef struct packed {
		logic [`F2H_ADDR_W-1:0] addr;
		logic [2:0]             prot;
	} axi_ar_t;

	typedef struct packed {
		logic [`F2H_DATA_W-1:0] data;
		logic [1:0]             resp;
	} axi_r_t;

	typedef struct packed {
		logic [`F2H_ADDR_W-1:0] addr;
		logic [2:0]             prot;
	} axi_aw_t;

	typedef struct packed {
		logic [`F2H_DATA_W-1:0]   data;
		logic [`F2H_DATA_W/8-1:0] strb;
		logic                     last;
	} axi_w_t;

	// One read or write, as issued by the printer
	typedef struct packed {
		logic                   write;
		logic [`F2H_ADDR_W-1:0] addr;
		logic [`F2H_DATA_W-1:0] wdata;
	} axi_cmd_t;

endpackage

/* logic/uart_pkg.sv */
// -----------------------------------------------
// Print requests and the UART read-back word
// -----------------------------------------------
`include "f2h_uart_consts.svh"

package uart_pkg;

	typedef enum logic {
		REQ_CHAR = 1'b0,
		REQ_WORD = 1'b1
	} req_kind_e;

	// Character to print, or address of a word to print in hex
	typedef struct packed {
		req_kind_e              kind;
		logic [7:0]             ch;
		logic [`F2H_ADDR_W-1:0] addr;
	} print_req_t;

	// Line status register flags, transmit-empty at bit 5
	typedef struct packed {
		logic [23:0] rsvd;
		logic        rfe;
		logic        temt;
		logic        thre;
		logic        bi;
		logic        fe;
		logic        pe;
		logic        oe;
		logic        dr;
	} uart_lsr_t;

	// Poll result or word to print, same 32 bits
	typedef union packed {
		uart_lsr_t       lsr;
		logic [7:0][3:0] nib;
	} uart_word_u;

endpackage

/* logic/key_debounce.sv */
// -----------------------------------------------
// Synchronizer and debouncer for one active-low key
// -----------------------------------------------
`timescale 1ns/1ps
`include "f2h_uart_consts.svh"

module key_debounce #(
	parameter int stable_cycles = `F2H_DEBOUNCE_CYCLES
) (
	input  logic FPGA_CLK1_50,
	input  logic my_reset,
	input  logic key_n,
	output logic key_level
);
	localparam int cnt_w = $clog2(stable_cycles + 1);
	localparam logic [cnt_w-1:0] cnt_limit = cnt_w'(stable_cycles);

	logic [1:0]       key_sync;
	logic             key_prev;
	logic [cnt_w-1:0] stable_cnt;

	always_ff @(posedge FPGA_CLK1_50 or posedge my_reset) begin
		if (my_reset) begin
			key_sync   <= '0;
			key_prev   <= 1'b0;
			stable_cnt <= '0;
			key_level  <= 1'b0;
		end else begin
			// Inverted so a pressed key reads 1
			key_sync <= {key_sync[0], ~key_n};
			key_prev <= key_sync[1];
			if (key_sync[1] != key_prev) begin
				stable_cnt <= '0;
			end else if (stable_cnt != cnt_limit) begin
				stable_cnt <= stable_cnt + 1'b1;
			end
			if (stable_cnt == cnt_limit) begin
				key_level <= key_prev;
			end
		end
	end

	a_level_settled: assert property (@(posedge FPGA_CLK1_50) disable iff (my_reset)
		!$stable(key_level) |-> $past(stable_cnt) == cnt_limit)
		else $error("key_level changed before the key was stable");

endmodule

/* logic/msg_sequencer.sv */
// -----------------------------------------------
// Message sequencer, hello and prefix strings
// followed by one word print
// -----------------------------------------------
`timescale 1ns/1ps
`include "f2h_uart_consts.svh"

module msg_sequencer (
	input  logic                       FPGA_CLK1_50,
	input  logic                       my_reset,
	input  logic [`F2H_KEY_COUNT-1:0]  key_level,
	output uart_pkg::print_req_t       req,
	output logic                       req_strobe,
	input  logic                       req_done
);
	localparam int idx_w = $clog2(`F2H_HELLO_LEN);
	localparam logic [8*`F2H_HELLO_LEN-1:0] hello_msg =
		{"Hello from the FPGA side", 8'h0D, 8'h0A};
	localparam logic [8*`F2H_PREFIX_LEN-1:0] prefix_msg = "0xFFC020F8: ";

	typedef enum logic [2:0] {
		S_IDLE,
		S_RELEASE,
		S_HELLO,
		S_PREFIX,
		S_WORD
	} seq_state_e;

	seq_state_e       state;
	logic [idx_w-1:0] char_idx;
	logic             sel_short;
	logic             busy;

	always_ff @(posedge FPGA_CLK1_50 or posedge my_reset) begin
		if (my_reset) begin
			state      <= S_IDLE;
			char_idx   <= '0;
			sel_short  <= 1'b0;
			busy       <= 1'b0;
			req        <= '0;
			req_strobe <= 1'b0;
		end else begin
			req_strobe <= 1'b0;
			case (state)
				S_IDLE: begin
					if (key_level[0]) begin
						sel_short <= 1'b0;
						state     <= S_RELEASE;
					end else if (key_level[1]) begin
						sel_short <= 1'b1;
						state     <= S_RELEASE;
					end
				end
				// Start on release of the key that was pressed
				S_RELEASE: begin
					if (!key_level[sel_short]) begin
						char_idx <= sel_short ? idx_w'(`F2H_PREFIX_LEN - 1)
							: idx_w'(`F2H_HELLO_LEN - 1);
						state    <= sel_short ? S_PREFIX : S_HELLO;
					end
				end
				S_HELLO, S_PREFIX: begin
					if (!busy) begin
						req.kind   <= uart_pkg::REQ_CHAR;
						req.ch     <= (state == S_HELLO) ? hello_msg[8*char_idx +: 8]
							: prefix_msg[8*char_idx +: 8];
						req.addr   <= '0;
						req_strobe <= 1'b1;
						busy       <= 1'b1;
					end else if (req_done) begin
						busy <= 1'b0;
						if (char_idx != '0) begin
							char_idx <= char_idx - 1'b1;
						end else if (state == S_HELLO) begin
							char_idx <= idx_w'(`F2H_PREFIX_LEN - 1);
							state    <= S_PREFIX;
						end else begin
							state <= S_WORD;
						end
					end
				end
				S_WORD: begin
					if (!busy) begin
						req.kind   <= uart_pkg::REQ_WORD;
						req.ch     <= 8'h00;
						req.addr   <= `F2H_UART_VER_ADDR;
						req_strobe <= 1'b1;
						busy       <= 1'b1;
					end else if (req_done) begin
						busy  <= 1'b0;
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	a_one_request: assert property (@(posedge FPGA_CLK1_50) disable iff (my_reset)
		req_strobe |=> (!req_strobe until req_done))
		else $error("req_strobe issued before req_done");

endmodule

/* logic/uart_printer.sv */
// -----------------------------------------------
// UART printer, LSR polling, THR writes and
// hex conversion of a read word
// -----------------------------------------------
`timescale 1ns/1ps
`include "f2h_uart_consts.svh"

module uart_printer (
	input  logic                 FPGA_CLK1_50,
	input  logic                 my_reset,
	input  uart_pkg::print_req_t req,
	input  logic                 req_strobe,
	output logic                 req_done,
	output axi_pkg::axi_cmd_t    cmd,
	output logic                 cmd_strobe,
	input  logic                 cmd_done,
	input  uart_pkg::uart_word_u rdata
);
	typedef enum logic [2:0] {
		P_IDLE,
		P_POLL,
		P_POLL_WAIT,
		P_WRITE,
		P_WRITE_WAIT,
		P_WORD_WAIT
	} prn_state_e;

	prn_state_e           state;
	logic                 word_mode;
	logic [3:0]           out_idx;
	logic [7:0]           ch_q;
	uart_pkg::uart_word_u word_q;
	logic                 thre_seen;

	// Digits 0 to 7 most significant first, then CR and LF
	function automatic logic [7:0] word_char(input logic [3:0] idx,
		input uart_pkg::uart_word_u word);
		logic [3:0] nib;
		nib = word.nib[~idx[2:0]];
		case (idx)
			4'd8:    word_char = 8'h0D;
			4'd9:    word_char = 8'h0A;
			default: word_char = (nib < 4'd10) ? 8'h30 + {4'h0, nib} : 8'h37 + {4'h0, nib};
		endcase
	endfunction

	always_ff @(posedge FPGA_CLK1_50 or posedge my_reset) begin
		if (my_reset) begin
			state      <= P_IDLE;
			word_mode  <= 1'b0;
			out_idx    <= '0;
			ch_q       <= '0;
			word_q     <= '0;
			thre_seen  <= 1'b0;
			cmd        <= '0;
			cmd_strobe <= 1'b0;
			req_done   <= 1'b0;
		end else begin
			cmd_strobe <= 1'b0;
			req_done   <= 1'b0;
			case (state)
				P_IDLE: begin
					if (req_strobe) begin
						word_mode <= (req.kind == uart_pkg::REQ_WORD);
						out_idx   <= '0;
						ch_q      <= req.ch;
						if (req.kind == uart_pkg::REQ_WORD) begin
							cmd        <= '{write: 1'b0, addr: req.addr, wdata: '0};
							cmd_strobe <= 1'b1;
							state      <= P_WORD_WAIT;
						end else begin
							state <= P_POLL;
						end
					end
				end
				P_WORD_WAIT: begin
					if (cmd_done) begin
						word_q <= rdata;
						ch_q   <= word_char(4'd0, rdata);
						state  <= P_POLL;
					end
				end
				// -----------------------------------------------
				// Poll LSR until the transmit holding register is empty
				// -----------------------------------------------
				P_POLL: begin
					cmd        <= '{write: 1'b0, addr: `F2H_UART_BASE + `F2H_UART_LSR_OFS,
						wdata: '0};
					cmd_strobe <= 1'b1;
					state      <= P_POLL_WAIT;
				end
				P_POLL_WAIT: begin
					if (cmd_done) begin
						thre_seen <= rdata[`F2H_LSR_THRE_BIT];
						state     <= rdata.lsr.thre ? P_WRITE : P_POLL;
					end
				end
				P_WRITE: begin
					cmd        <= '{write: 1'b1, addr: `F2H_UART_BASE + `F2H_UART_THR_OFS,
						wdata: {{(`F2H_DATA_W - 8){1'b0}}, ch_q}};
					cmd_strobe <= 1'b1;
					state      <= P_WRITE_WAIT;
				end
				P_WRITE_WAIT: begin
					if (cmd_done) begin
						thre_seen <= 1'b0;
						if (word_mode && out_idx != 4'd9) begin
							out_idx <= out_idx + 4'd1;
							ch_q    <= word_char(out_idx + 4'd1, word_q);
							state   <= P_POLL;
						end else begin
							req_done <= 1'b1;
							state    <= P_IDLE;
						end
					end
				end
				default: state <= P_IDLE;
			endcase
		end
	end

	a_write_after_thre: assert property (@(posedge FPGA_CLK1_50) disable iff (my_reset)
		cmd_strobe && cmd.write |-> thre_seen)
		else $error("THR write without a transmit-empty LSR read");

endmodule

/* logic/axi_single_master.sv */
// -----------------------------------------------
// Single-beat read and write master
// -----------------------------------------------
`timescale 1ns/1ps
`include "f2h_uart_consts.svh"

module axi_single_master (
	input  logic                   FPGA_CLK1_50,
	input  logic                   my_reset,
	input  axi_pkg::axi_cmd_t      cmd,
	input  logic                   cmd_strobe,
	output logic                   cmd_done,
	output logic [`F2H_DATA_W-1:0] rdata,
	output axi_pkg::axi_ar_t       ar,
	output logic                   ar_valid,
	input  logic                   ar_ready,
	input  axi_pkg::axi_r_t        r,
	input  logic                   r_valid,
	output logic                   r_ready,
	output axi_pkg::axi_aw_t       aw,
	output logic                   aw_valid,
	input  logic                   aw_ready,
	output axi_pkg::axi_w_t        w,
	output logic                   w_valid,
	input  logic                   w_ready,
	input  logic [1:0]             b_resp,
	input  logic                   b_valid,
	output logic                   b_ready
);
	typedef enum logic [1:0] {
		M_IDLE,
		M_READ,
		M_WRITE,
		M_RESP
	} mst_state_e;

	mst_state_e state;
	logic       aw_hs;
	logic       w_hs;

	assign aw_hs = aw_valid && aw_ready;
	assign w_hs  = w_valid && w_ready;

	always_ff @(posedge FPGA_CLK1_50 or posedge my_reset) begin
		if (my_reset) begin
			state    <= M_IDLE;
			ar       <= '0;
			aw       <= '0;
			w        <= '0;
			ar_valid <= 1'b0;
			r_ready  <= 1'b0;
			aw_valid <= 1'b0;
			w_valid  <= 1'b0;
			b_ready  <= 1'b0;
			cmd_done <= 1'b0;
			rdata    <= '0;
		end else begin
			cmd_done <= 1'b0;
			case (state)
				M_IDLE: begin
					if (cmd_strobe && cmd.write) begin
						aw       <= '{addr: cmd.addr, prot: 3'b000};
						w        <= '{data: cmd.wdata, strb: 4'b0001, last: 1'b1};
						aw_valid <= 1'b1;
						w_valid  <= 1'b1;
						state    <= M_WRITE;
					end else if (cmd_strobe) begin
						ar       <= '{addr: cmd.addr, prot: 3'b000};
						ar_valid <= 1'b1;
						r_ready  <= 1'b1;
						state    <= M_READ;
					end
				end
				M_READ: begin
					if (ar_valid && ar_ready) begin
						ar_valid <= 1'b0;
					end
					if (r_valid && r_ready) begin
						r_ready  <= 1'b0;
						rdata    <= r.data;
						cmd_done <= 1'b1;
						state    <= M_IDLE;
					end
				end
				// Address and data complete in either order
				M_WRITE: begin
					if (aw_hs) begin
						aw_valid <= 1'b0;
					end
					if (w_hs) begin
						w_valid <= 1'b0;
					end
					if ((!aw_valid || aw_hs) && (!w_valid || w_hs)) begin
						b_ready <= 1'b1;
						state   <= M_RESP;
					end
				end
				M_RESP: begin
					if (b_valid) begin
						b_ready  <= 1'b0;
						cmd_done <= 1'b1;
						state    <= M_IDLE;
					end
				end
				default: state <= M_IDLE;
			endcase
		end
	end

	// -----------------------------------------------
	// Channel rules
	// -----------------------------------------------
	a_ar_hold: assert property (@(posedge FPGA_CLK1_50) disable iff (my_reset)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar))
		else $error("ar_valid or ar changed before ar_ready");
	a_aw_hold: assert property (@(posedge FPGA_CLK1_50) disable iff (my_reset)
		aw_valid && !aw_ready |=> aw_valid && $stable(aw))
		else $error("aw_valid or aw changed before aw_ready");
	a_w_hold: assert property (@(posedge FPGA_CLK1_50) disable iff (my_reset)
		w_valid && !w_ready |=> w_valid && $stable(w))
		else $error("w_valid or w changed before w_ready");
	a_resp_okay: assert property (@(posedge FPGA_CLK1_50) disable iff (my_reset)
		(r_valid && r_ready |-> r.resp == 2'b00) and (b_valid && b_ready |-> b_resp == 2'b00))
		else $error("Bridge returned an error response");

endmodule

/* logic/f2h_uart_tx.sv */
// -----------------------------------------------
// Key-triggered UART message over the bridge
// -----------------------------------------------
`timescale 1ns/1ps
`include "f2h_uart_consts.svh"

module f2h_uart_tx #(
	parameter int debounce_cycles = `F2H_DEBOUNCE_CYCLES
) (
	input  logic                      FPGA_CLK1_50,
	input  logic                      my_reset,
	input  logic [`F2H_KEY_COUNT-1:0] key,
	output logic [`F2H_KEY_COUNT-1:0] led,
	output axi_pkg::axi_ar_t          ar,
	output logic                      ar_valid,
	input  logic                      ar_ready,
	input  axi_pkg::axi_r_t           r,
	input  logic                      r_valid,
	output logic                      r_ready,
	output axi_pkg::axi_aw_t          aw,
	output logic                      aw_valid,
	input  logic                      aw_ready,
	output axi_pkg::axi_w_t           w,
	output logic                      w_valid,
	input  logic                      w_ready,
	input  logic [1:0]                b_resp,
	input  logic                      b_valid,
	output logic                      b_ready
);
	logic [`F2H_KEY_COUNT-1:0] key_level;
	uart_pkg::print_req_t      req;
	logic                      req_strobe;
	logic                      req_done;
	axi_pkg::axi_cmd_t         cmd;
	logic                      cmd_strobe;
	logic                      cmd_done;
	logic [`F2H_DATA_W-1:0]    rdata;

	// Push buttons
	for (genvar gi = 0; gi < `F2H_KEY_COUNT; gi++) begin : g_key
		key_debounce #(
			.stable_cycles(debounce_cycles)
		) u_key_debounce (
			.FPGA_CLK1_50(FPGA_CLK1_50),
			.my_reset(my_reset),
			.key_n(key[gi]),
			.key_level(key_level[gi])
		);
	end

	assign led = key_level;

	msg_sequencer u_msg_sequencer (
		.FPGA_CLK1_50(FPGA_CLK1_50),
		.my_reset(my_reset),
		.key_level(key_level),
		.req(req),
		.req_strobe(req_strobe),
		.req_done(req_done)
	);

	uart_printer u_uart_printer (
		.FPGA_CLK1_50(FPGA_CLK1_50),
		.my_reset(my_reset),
		.req(req),
		.req_strobe(req_strobe),
		.req_done(req_done),
		.cmd(cmd),
		.cmd_strobe(cmd_strobe),
		.cmd_done(cmd_done),
		.rdata(rdata)
	);

	// Bridge side
	axi_single_master u_axi_single_master (
		.FPGA_CLK1_50(FPGA_CLK1_50),
		.my_reset(my_reset),
		.cmd(cmd),
		.cmd_strobe(cmd_strobe),
		.cmd_done(cmd_done),
		.rdata(rdata),
		.ar(ar),
		.ar_valid(ar_valid),
		.ar_ready(ar_ready),
		.r(r),
		.r_valid(r_valid),
		.r_ready(r_ready),
		.aw(aw),
		.aw_valid(aw_valid),
		.aw_ready(aw_ready),
		.w(w),
		.w_valid(w_valid),
		.w_ready(w_ready),
		.b_resp(b_resp),
		.b_valid(b_valid),
		.b_ready(b_ready)
	);

endmodule

/* tests/hps_uart_model.sv */
// -----------------------------------------------
// Bridge responder with UART LSR, THR and version
// register, random ready delays, byte record
// -----------------------------------------------
`timescale 1ns/1ps
`include "f2h_uart_consts.svh"

module hps_uart_model (
	input  logic                   FPGA_CLK1_50,
	input  logic                   my_reset,
	input  logic [`F2H_DATA_W-1:0] ver_word,
	input  axi_pkg::axi_ar_t       ar,
	input  logic                   ar_valid,
	output logic                   ar_ready,
	output axi_pkg::axi_r_t        r,
	output logic                   r_valid,
	input  logic                   r_ready,
	input  axi_pkg::axi_aw_t       aw,
	input  logic                   aw_valid,
	output logic                   aw_ready,
	input  axi_pkg::axi_w_t        w,
	input  logic                   w_valid,
	output logic                   w_ready,
	output logic [1:0]             b_resp,
	output logic                   b_valid,
	input  logic                   b_ready,
	output logic                   tx_strobe,
	output logic [7:0]             tx_byte
);
	localparam logic [`F2H_ADDR_W-1:0] thr_addr = `F2H_UART_BASE + `F2H_UART_THR_OFS;
	localparam logic [`F2H_ADDR_W-1:0] lsr_addr = `F2H_UART_BASE + `F2H_UART_LSR_OFS;

	int seed = 5;
	int ar_dly;
	int r_dly;
	int aw_dly;
	int w_dly;
	int b_dly;
	// LSR polls left that still report the transmitter busy
	int busy_polls;
	logic rd_pending;
	logic aw_done;
	logic w_done;
	logic thr_empty;
	logic [`F2H_ADDR_W-1:0] rd_addr;
	logic [`F2H_ADDR_W-1:0] wr_addr;
	logic [`F2H_DATA_W-1:0] rd_data;
	logic [`F2H_DATA_W-1:0] wr_data;

	function automatic int rand_below(input int n);
		rand_below = int'($unsigned($random(seed)) % n);
	endfunction

	assign thr_empty = (busy_polls == 0);

	// Every ready is raised only while its valid is high, so a raised
	// ready always completes a handshake on the next rising edge
	always @(negedge FPGA_CLK1_50 or posedge my_reset) begin
		if (my_reset) begin
			ar_ready   <= 1'b0;
			r          <= '0;
			r_valid    <= 1'b0;
			aw_ready   <= 1'b0;
			w_ready    <= 1'b0;
			b_resp     <= 2'b00;
			b_valid    <= 1'b0;
			tx_strobe  <= 1'b0;
			tx_byte    <= 8'h00;
			ar_dly     <= 0;
			r_dly      <= 0;
			aw_dly     <= 0;
			w_dly      <= 0;
			b_dly      <= 0;
			busy_polls <= 0;
			rd_pending <= 1'b0;
			aw_done    <= 1'b0;
			w_done     <= 1'b0;
			rd_addr    <= '0;
			wr_addr    <= '0;
			rd_data    <= '0;
			wr_data    <= '0;
		end else begin
			tx_strobe <= 1'b0;
			// -----------------------------------------------
			// Read address and read data
			// -----------------------------------------------
			if (ar_ready) begin
				ar_ready   <= 1'b0;
				rd_pending <= 1'b1;
				ar_dly     <= rand_below(4);
				if (rd_addr == lsr_addr) begin
					// TEMT held clear since the shift register is not modeled
					rd_data <= {24'h000000, 1'b0, 1'b0, thr_empty, 5'h00};
					if (!thr_empty) begin
						busy_polls <= busy_polls - 1;
					end
				end else if (rd_addr == `F2H_UART_VER_ADDR) begin
					rd_data <= ver_word;
				end else begin
					rd_data <= '0;
				end
			end else if (ar_valid && !rd_pending) begin
				if (ar_dly != 0) begin
					ar_dly <= ar_dly - 1;
				end else begin
					ar_ready <= 1'b1;
					rd_addr  <= ar.addr;
				end
			end
			if (r_valid) begin
				r_valid    <= 1'b0;
				rd_pending <= 1'b0;
				r_dly      <= rand_below(4);
			end else if (rd_pending) begin
				if (r_dly != 0) begin
					r_dly <= r_dly - 1;
				end else if (r_ready) begin
					r_valid <= 1'b1;
					r       <= '{data: rd_data, resp: 2'b00};
				end
			end
			// -----------------------------------------------
			// Write address, write data and response
			// -----------------------------------------------
			if (aw_ready) begin
				aw_ready <= 1'b0;
				aw_done  <= 1'b1;
				aw_dly   <= rand_below(4);
			end else if (aw_valid && !aw_done) begin
				if (aw_dly != 0) begin
					aw_dly <= aw_dly - 1;
				end else begin
					aw_ready <= 1'b1;
					wr_addr  <= aw.addr;
				end
			end
			if (w_ready) begin
				w_ready <= 1'b0;
				w_done  <= 1'b1;
				w_dly   <= rand_below(4);
			end else if (w_valid && !w_done) begin
				if (w_dly != 0) begin
					w_dly <= w_dly - 1;
				end else begin
					w_ready <= 1'b1;
					wr_data <= w.data;
				end
			end
			if (b_valid) begin
				b_valid <= 1'b0;
			end else if (aw_done && w_done) begin
				if (b_dly != 0) begin
					b_dly <= b_dly - 1;
				end else if (b_ready) begin
					b_valid <= 1'b1;
					aw_done <= 1'b0;
					w_done  <= 1'b0;
					b_dly   <= rand_below(4);
					// Character leaves, transmitter busy for a few polls
					if (wr_addr == thr_addr) begin
						tx_strobe  <= 1'b1;
						tx_byte    <= wr_data[7:0];
						busy_polls <= rand_below(3);
					end
				end
			end
		end
	end

endmodule

/* tests/tb_f2h_uart_tx.sv */
// -----------------------------------------------
// Testbench for the key-triggered UART message,
// bus rule assertions and byte stream checks
// -----------------------------------------------
`timescale 1ns/1ps
`include "f2h_uart_consts.svh"

module tb_f2h_uart_tx;
	localparam int debounce_len = 8;
	localparam int timeout_cycles = 20000;
	localparam logic [`F2H_ADDR_W-1:0] thr_addr = `F2H_UART_BASE + `F2H_UART_THR_OFS;
	localparam logic [`F2H_ADDR_W-1:0] lsr_addr = `F2H_UART_BASE + `F2H_UART_LSR_OFS;

	logic FPGA_CLK1_50 = 1'b0;
	logic my_reset;
	logic [`F2H_KEY_COUNT-1:0] key;
	logic [`F2H_KEY_COUNT-1:0] led;
	axi_pkg::axi_ar_t ar;
	logic             ar_valid;
	logic             ar_ready;
	axi_pkg::axi_r_t  r;
	logic             r_valid;
	logic             r_ready;
	axi_pkg::axi_aw_t aw;
	logic             aw_valid;
	logic             aw_ready;
	axi_pkg::axi_w_t  w;
	logic             w_valid;
	logic             w_ready;
	logic [1:0]       b_resp;
	logic             b_valid;
	logic             b_ready;
	logic             tx_strobe;
	logic [7:0]       tx_byte;

	logic [`F2H_DATA_W-1:0] ver_word;
	logic [7:0] exp_q[$];
	logic [7:0] exp_b;
	int seed;
	int errors = 0;
	int rule_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	logic bounce_phase = 1'b0;
	logic lsr_pending;
	logic thre_ok;

	always #2 FPGA_CLK1_50 = ~FPGA_CLK1_50;

	f2h_uart_tx #(
		.debounce_cycles(debounce_len)
	) u_f2h_uart_tx (
		.FPGA_CLK1_50(FPGA_CLK1_50),
		.my_reset(my_reset),
		.key(key),
		.led(led),
		.ar(ar),
		.ar_valid(ar_valid),
		.ar_ready(ar_ready),
		.r(r),
		.r_valid(r_valid),
		.r_ready(r_ready),
		.aw(aw),
		.aw_valid(aw_valid),
		.aw_ready(aw_ready),
		.w(w),
		.w_valid(w_valid),
		.w_ready(w_ready),
		.b_resp(b_resp),
		.b_valid(b_valid),
		.b_ready(b_ready)
	);

	hps_uart_model u_hps_uart_model (
		.FPGA_CLK1_50(FPGA_CLK1_50),
		.my_reset(my_reset),
		.ver_word(ver_word),
		.ar(ar),
		.ar_valid(ar_valid),
		.ar_ready(ar_ready),
		.r(r),
		.r_valid(r_valid),
		.r_ready(r_ready),
		.aw(aw),
		.aw_valid(aw_valid),
		.aw_ready(aw_ready),
		.w(w),
		.w_valid(w_valid),
		.w_ready(w_ready),
		.b_resp(b_resp),
		.b_valid(b_valid),
		.b_ready(b_ready),
		.tx_strobe(tx_strobe),
		.tx_byte(tx_byte)
	);

	// Compare each character leaving the UART with the expected stream
	always @(posedge FPGA_CLK1_50) begin
		if (!my_reset && tx_strobe) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("Unexpected THR write of 0x%h with no byte expected", tx_byte);
			end else begin
				exp_b = exp_q.pop_front();
				assert (tx_byte == exp_b) else begin
					errors++;
					$display("ERROR tx_byte: got 0x%h, expected 0x%h", tx_byte, exp_b);
				end
			end
		end
	end

	// Transmit-empty flag from the most recent LSR read
	always @(posedge FPGA_CLK1_50 or posedge my_reset) begin
		if (my_reset) begin
			lsr_pending <= 1'b0;
			thre_ok     <= 1'b0;
		end else begin
			if (ar_valid && ar_ready) begin
				lsr_pending <= (ar.addr == lsr_addr);
			end
			if (r_valid && r_ready && lsr_pending) begin
				thre_ok <= r.data[`F2H_LSR_THRE_BIT];
			end
			if (aw_valid && aw_ready) begin
				thre_ok <= 1'b0;
			end
		end
	end

	// -----------------------------------------------
	// Bus rules
	// -----------------------------------------------
	a_thre_first: assert property (@(posedge FPGA_CLK1_50) disable iff (my_reset)
		aw_valid && aw_ready && aw.addr == thr_addr |-> thre_ok)
		else begin
			rule_errors++;
			$display("THR write issued without an LSR read showing transmit-empty");
		end
	a_w_beat: assert property (@(posedge FPGA_CLK1_50) disable iff (my_reset)
		w_valid |-> w.strb == 4'b0001 && w.last)
		else begin
			rule_errors++;
			$display("ERROR w.strb 0x%h w.last 0x%h, expected 0x1 and 0x1",
				$sampled(w.strb), $sampled(w.last));
		end
	a_ar_hold: assert property (@(posedge FPGA_CLK1_50) disable iff (my_reset)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar))
		else begin
			rule_errors++;
			$display("ar_valid or its payload changed before ar_ready");
		end
	a_aw_hold: assert property (@(posedge FPGA_CLK1_50) disable iff (my_reset)
		aw_valid && !aw_ready |=> aw_valid && $stable(aw))
		else begin
			rule_errors++;
			$display("aw_valid or its payload changed before aw_ready");
		end
	a_w_hold: assert property (@(posedge FPGA_CLK1_50) disable iff (my_reset)
		w_valid && !w_ready |=> w_valid && $stable(w))
		else begin
			rule_errors++;
			$display("w_valid or its payload changed before w_ready");
		end

	// Bouncing key must stay invisible
	a_bounce_led: assert property (@(posedge FPGA_CLK1_50) bounce_phase |-> led == '0)
		else begin
			errors++;
			$display("ERROR led during bounce: got 0x%h, expected 0x0", $sampled(led));
		end
	a_bounce_bus: assert property (@(posedge FPGA_CLK1_50)
		bounce_phase |-> !ar_valid && !aw_valid)
		else begin
			errors++;
			$display("Bus traffic started while a key was bouncing");
		end

	task automatic check_bus_idle(input string when_txt);
		logic [4:0] flags;
		flags = {ar_valid, aw_valid, w_valid, r_ready, b_ready};
		assert (flags == 5'b00000) else begin
			errors++;
			$display("ERROR {ar_valid,aw_valid,w_valid,r_ready,b_ready} %s: got 0x%h, expected 0x00",
				when_txt, flags);
		end
		assert (led == '0) else begin
			errors++;
			$display("ERROR led %s: got 0x%h, expected 0x0", when_txt, led);
		end
	endtask

	// Expected stream, built from the message text and the version word
	task automatic queue_message(input logic with_hello);
		string hello;
		string prefix;
		string hexdig;
		int i;
		hello = "Hello from the FPGA side";
		prefix = "0xFFC020F8: ";
		hexdig = "0123456789ABCDEF";
		exp_q.delete();
		if (with_hello) begin
			for (i = 0; i < hello.len(); i++) begin
				exp_q.push_back(hello[i]);
			end
			exp_q.push_back(8'h0D);
			exp_q.push_back(8'h0A);
		end
		for (i = 0; i < prefix.len(); i++) begin
			exp_q.push_back(prefix[i]);
		end
		for (i = 7; i >= 0; i--) begin
			exp_q.push_back(hexdig[ver_word[4*i +: 4]]);
		end
		exp_q.push_back(8'h0D);
		exp_q.push_back(8'h0A);
	endtask

	task automatic wait_led(input int idx, input logic level);
		int cycles;
		cycles = 0;
		while (led[idx] !== level && cycles < timeout_cycles) begin
			@(negedge FPGA_CLK1_50);
			cycles++;
		end
		if (led[idx] !== level) begin
			errors++;
			$display("Timed out waiting for led[%0d] to become %0d", idx, level);
		end
	endtask

	task automatic wait_for_bytes();
		int cycles;
		cycles = 0;
		while (exp_q.size() != 0 && cycles < timeout_cycles) begin
			@(negedge FPGA_CLK1_50);
			cycles++;
		end
		if (exp_q.size() != 0) begin
			errors++;
			$display("Timed out with %0d message bytes never transmitted", exp_q.size());
		end
	endtask

	task automatic wait_bus_quiet();
		int cycles;
		int idle;
		cycles = 0;
		idle = 0;
		while (idle < 16 && cycles < timeout_cycles) begin
			@(negedge FPGA_CLK1_50);
			cycles++;
			if (ar_valid || aw_valid || w_valid || r_ready || b_ready) begin
				idle = 0;
			end else begin
				idle++;
			end
		end
		if (idle < 16) begin
			errors++;
			$display("Timed out waiting for the bus to go quiet");
		end
	endtask

	// Low and high pulses of 1 to 6 cycles, ending released
	task automatic bounce_key(input int idx, input int pulses);
		int n;
		int len;
		for (n = 0; n < pulses; n++) begin
			len = 1 + int'($unsigned($random(seed)) % 6);
			key[idx] = 1'b0;
			repeat (len) @(negedge FPGA_CLK1_50);
			len = 1 + int'($unsigned($random(seed)) % 6);
			key[idx] = 1'b1;
			repeat (len) @(negedge FPGA_CLK1_50);
		end
	endtask

	task automatic finish_test(input string name, input int failures);
		tests_run++;
		if (failures == 0) begin
			$display("Test %s: PASS", name);
		end else begin
			tests_failed++;
			$display("Test %s: FAIL with %0d errors", name, failures);
		end
	endtask

	initial begin
		int first;
		seed = 5;
		ver_word = $random(seed);
		key = '1;
		my_reset = 1'b1;

		first = errors;
		repeat (3) @(posedge FPGA_CLK1_50);
		@(negedge FPGA_CLK1_50);
		check_bus_idle("during reset");
		my_reset = 1'b0;
		repeat (4) begin
			@(negedge FPGA_CLK1_50);
			check_bus_idle("after reset");
		end
		finish_test("reset state", errors - first);

		// Key 0, full message
		first = errors;
		queue_message(1'b1);
		key[0] = 1'b0;
		wait_led(0, 1'b1);
		key[0] = 1'b1;
		wait_led(0, 1'b0);
		wait_for_bytes();
		wait_bus_quiet();
		finish_test("key 0 full message", errors - first);

		// Short pulses on key 0, then a stable press of key 1
		first = errors;
		bounce_phase = 1'b1;
		bounce_key(0, 12);
		repeat (4 * debounce_len) @(negedge FPGA_CLK1_50);
		bounce_phase = 1'b0;
		queue_message(1'b0);
		key[1] = 1'b0;
		wait_led(1, 1'b1);
		finish_test("bounce filter and stable press", errors - first);

		// Release of key 1 sends the short message
		first = errors;
		key[1] = 1'b1;
		wait_led(1, 1'b0);
		wait_for_bytes();
		wait_bus_quiet();
		finish_test("key 1 short message", errors - first);

		finish_test("bus channel rules", rule_errors);

		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
			errors + rule_errors);
		if (errors + rule_errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* verilog.f */
+incdir+include
logic/axi_pkg.sv
logic/uart_pkg.sv
logic/key_debounce.sv
logic/msg_sequencer.sv
logic/uart_printer.sv
logic/axi_single_master.sv
logic/f2h_uart_tx.sv
tests/hps_uart_model.sv
tests/tb_f2h_uart_tx.sv

/* Makefile */
# Verilator build and run of the UART message testbench
TOP := tb_f2h_uart_tx

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -f verilog.f \
		--top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir
